// File: dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and data widths
`define DCACHE_ADDR_W 32
`define DCACHE_WORD_W 32
`define DCACHE_LINE_W 256

// geometry, 2 ways of 512 sets with 32-byte lines
`define DCACHE_SETS 512
`define DCACHE_TAG_W 18
`define DCACHE_INDEX_W 9
`define DCACHE_OFFSET_W 5
`define DCACHE_WORDS 8

// miss sequence timing in cycles
`define DCACHE_MISS_CYCLES 11
`define DCACHE_WB_CYCLE 1

// shown on the memory address bus between transfers
`define DCACHE_IDLE_ADDR 32'hdead_beef

`endif

// File: dcache_addr_pkg.sv
`include "dcache_defs.svh"

package dcache_addr_pkg;

	typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
	typedef logic [`DCACHE_TAG_W-1:0] tag_t;
	typedef logic [`DCACHE_INDEX_W-1:0] index_t;
	typedef logic [`DCACHE_OFFSET_W-3:0] word_sel_t;

	function automatic tag_t addr_tag(addr_t a);
		return a[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
	endfunction

	function automatic word_sel_t addr_word_sel(addr_t a);
		return a[`DCACHE_OFFSET_W-1:2];
	endfunction

	// line-aligned address from tag and set
	function automatic addr_t block_addr(tag_t t, index_t i);
		return {t, i, {`DCACHE_OFFSET_W{1'b0}}};
	endfunction

endpackage

// File: dcache_line_pkg.sv
`include "dcache_defs.svh"

package dcache_line_pkg;

	typedef logic [`DCACHE_WORD_W-1:0] word_t;
	typedef logic [`DCACHE_LINE_W-1:0] line_t;

	// number of low-order bytes written by a store
	typedef enum logic [1:0] {
		SIZE_WORD   = 2'd0,
		SIZE_BYTE   = 2'd1,
		SIZE_HALF   = 2'd2,
		SIZE_TRIPLE = 2'd3
	} store_size_e;

	// one tag array entry, 20 bits
	typedef struct packed {
		logic [`DCACHE_TAG_W-1:0] tag;
		logic                     valid;
		logic                     dirty;
	} tag_entry_t;

	typedef logic way_t;

endpackage

// File: dcache_store_array.sv
`include "dcache_defs.svh"

module dcache_store_array #(
	parameter type entry_t = dcache_line_pkg::line_t
) (
	input  logic                    CLK,
	input  logic                    RESET,
	input  dcache_addr_pkg::index_t rd_index,
	input  logic                    wr_en,
	input  dcache_addr_pkg::index_t wr_index,
	input  entry_t                  wr_entry,
	output entry_t                  rd_entry
);

	entry_t mem [`DCACHE_SETS];

	// combinational read
	assign rd_entry = mem[rd_index];

	// one entry per set, written at the edge
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < `DCACHE_SETS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_index] <= wr_entry;
		end
	end

endmodule

// File: dcache_hit_path.sv
`include "dcache_defs.svh"

module dcache_hit_path (
	input  logic                         CLK,
	input  logic                         RESET,
	input  logic                         read,
	input  logic                         write,
	input  dcache_addr_pkg::addr_t       addr,
	input  dcache_line_pkg::store_size_e store_size,
	input  dcache_line_pkg::word_t       write_data,
	input  dcache_line_pkg::tag_entry_t  tag_entry0,
	input  dcache_line_pkg::tag_entry_t  tag_entry1,
	input  dcache_line_pkg::line_t       line0,
	input  dcache_line_pkg::line_t       line1,
	input  logic                         fill,
	input  dcache_line_pkg::line_t       fill_line,
	output dcache_line_pkg::word_t       read_data,
	output logic                         stall,
	output logic                         miss,
	output dcache_line_pkg::way_t        victim_way,
	output dcache_line_pkg::tag_entry_t  victim_entry,
	output dcache_line_pkg::line_t       victim_line,
	output logic                         tag_wr_en0,
	output logic                         tag_wr_en1,
	output logic                         data_wr_en0,
	output logic                         data_wr_en1,
	output dcache_line_pkg::tag_entry_t  tag_wr_entry,
	output dcache_line_pkg::line_t       data_wr_line
);

	import dcache_addr_pkg::*;
	import dcache_line_pkg::*;

	tag_t        req_tag;
	index_t      req_index;
	word_sel_t   req_word;
	logic        access;
	logic        hit0;
	logic        hit1;
	logic        hit;
	way_t        hit_way;
	line_t       hit_line;
	int unsigned word_lsb;
	word_t       old_word;
	word_t       byte_mask;
	word_t       merged_word;
	line_t       store_line;
	logic        store_hit;
	logic        way0_wr;
	logic        way1_wr;

	// last used way per set
	logic        repl [`DCACHE_SETS];

	assign req_tag   = addr_tag(addr);
	assign req_index = addr_index(addr);
	assign req_word  = addr_word_sel(addr);
	assign access    = read | write;

	assign hit0    = tag_entry0.valid && (tag_entry0.tag == req_tag);
	assign hit1    = tag_entry1.valid && (tag_entry1.tag == req_tag);
	assign hit     = access && (hit0 || hit1);
	assign hit_way = hit1;
	assign miss    = access && !(hit0 || hit1);
	assign stall   = miss;

	// word select 0 sits in the top 32 bits of the line
	assign hit_line  = hit_way ? line1 : line0;
	assign word_lsb  = (`DCACHE_WORDS - 1 - req_word) * `DCACHE_WORD_W;
	assign old_word  = hit_line[word_lsb +: `DCACHE_WORD_W];
	assign read_data = old_word;

	always_comb begin
		case (store_size)
			SIZE_BYTE:   byte_mask = 32'h0000_00ff;
			SIZE_HALF:   byte_mask = 32'h0000_ffff;
			SIZE_TRIPLE: byte_mask = 32'h00ff_ffff;
			default:     byte_mask = 32'hffff_ffff;
		endcase
	end

	assign merged_word = (old_word & ~byte_mask) | (write_data & byte_mask);

	always_comb begin
		store_line = hit_line;
		store_line[word_lsb +: `DCACHE_WORD_W] = merged_word;
	end

	// LRU victim is the way not used last
	assign victim_way   = ~repl[req_index];
	assign victim_entry = victim_way ? tag_entry1 : tag_entry0;
	assign victim_line  = victim_way ? line1 : line0;

	// store hits and fills never share a cycle
	assign store_hit = write && hit;
	assign way0_wr   = (store_hit && !hit_way) || (fill && !victim_way);
	assign way1_wr   = (store_hit && hit_way) || (fill && victim_way);

	assign tag_wr_en0  = way0_wr;
	assign tag_wr_en1  = way1_wr;
	assign data_wr_en0 = way0_wr;
	assign data_wr_en1 = way1_wr;

	// a fill lands clean, a store marks the line dirty
	assign tag_wr_entry = '{tag: req_tag, valid: 1'b1, dirty: ~fill};
	assign data_wr_line = fill ? fill_line : store_line;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < `DCACHE_SETS; i++) begin
				repl[i] <= 1'b0;
			end
		end else if (hit) begin
			repl[req_index] <= hit_way;
		end
	end

	a_rd_wr_excl: assert property (
		@(posedge CLK) disable iff (!RESET) !(read && write)
	);

	// fills only go to a missing tag, so a set never holds one tag twice
	a_single_hit: assert property (
		@(posedge CLK) disable iff (!RESET) !(hit0 && hit1)
	);

endmodule

// File: dcache_miss_seq.sv
`include "dcache_defs.svh"

module dcache_miss_seq (
	input  logic                        CLK,
	input  logic                        RESET,
	input  logic                        miss,
	input  dcache_addr_pkg::addr_t      addr,
	input  dcache_line_pkg::tag_entry_t victim_entry,
	input  dcache_line_pkg::line_t      victim_line,
	output logic                        fill,
	output logic                        blk_read,
	output logic                        blk_write,
	output dcache_addr_pkg::addr_t      mem_addr,
	output dcache_line_pkg::line_t      write_blk
);

	import dcache_addr_pkg::*;

	localparam int CNT_W = $clog2(`DCACHE_MISS_CYCLES);
	localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`DCACHE_MISS_CYCLES - 1);
	localparam logic [CNT_W-1:0] WB_CYCLE = CNT_W'(`DCACHE_WB_CYCLE);

	logic [CNT_W-1:0] cycle;
	logic             victim_dirty;
	tag_t             req_tag;
	index_t           req_index;

	assign req_tag      = addr_tag(addr);
	assign req_index    = addr_index(addr);
	assign victim_dirty = victim_entry.valid && victim_entry.dirty;

	// miss cycle count, sits at 0 while idle
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			cycle <= '0;
		end else if (!miss || cycle == LAST_CYCLE) begin
			cycle <= '0;
		end else begin
			cycle <= cycle + 1'b1;
		end
	end

	// writeback only for a dirty victim
	assign blk_write = miss && (cycle == WB_CYCLE) && victim_dirty;
	assign blk_read  = miss && (cycle == LAST_CYCLE);

	// refill data is captured at the end of the read cycle
	assign fill = blk_read;

	always_comb begin
		if (blk_read) begin
			mem_addr = block_addr(req_tag, req_index);
		end else if (blk_write) begin
			mem_addr = block_addr(victim_entry.tag, req_index);
		end else begin
			mem_addr = `DCACHE_IDLE_ADDR;
		end
	end

	assign write_blk = victim_line;

	a_one_strobe: assert property (
		@(posedge CLK) disable iff (!RESET) !(blk_read && blk_write)
	);

	// requester must hold the access for the whole miss
	a_addr_held: assert property (
		@(posedge CLK) disable iff (!RESET) miss ##1 miss |-> $stable(addr)
	);

endmodule

// File: dcache_top.sv
`include "dcache_defs.svh"

module dcache_top (
	input  logic                         CLK,
	input  logic                         RESET,
	input  logic                         read,
	input  logic                         write,
	input  dcache_addr_pkg::addr_t       addr,
	input  dcache_line_pkg::store_size_e store_size,
	input  dcache_line_pkg::word_t       write_data,
	input  dcache_line_pkg::line_t       read_blk,
	output dcache_line_pkg::word_t       read_data,
	output logic                         stall,
	output logic                         blk_read,
	output logic                         blk_write,
	output dcache_addr_pkg::addr_t       mem_addr,
	output dcache_line_pkg::line_t       write_blk
);

	import dcache_addr_pkg::*;
	import dcache_line_pkg::*;

	index_t     req_index;
	tag_entry_t tag_entry0;
	tag_entry_t tag_entry1;
	line_t      line0;
	line_t      line1;
	logic       miss;
	tag_entry_t victim_entry;
	line_t      victim_line;
	logic       fill;
	logic       tag_wr_en0;
	logic       tag_wr_en1;
	logic       data_wr_en0;
	logic       data_wr_en1;
	tag_entry_t tag_wr_entry;
	line_t      data_wr_line;

	// every read and write goes to the requested set
	assign req_index = addr_index(addr);

	dcache_store_array #(.entry_t(line_t)) u_data0 (
		.CLK(CLK), .RESET(RESET), .rd_index(req_index),
		.wr_en(data_wr_en0), .wr_index(req_index), .wr_entry(data_wr_line),
		.rd_entry(line0)
	);

	dcache_store_array #(.entry_t(line_t)) u_data1 (
		.CLK(CLK), .RESET(RESET), .rd_index(req_index),
		.wr_en(data_wr_en1), .wr_index(req_index), .wr_entry(data_wr_line),
		.rd_entry(line1)
	);

	dcache_store_array #(.entry_t(tag_entry_t)) u_tag0 (
		.CLK(CLK), .RESET(RESET), .rd_index(req_index),
		.wr_en(tag_wr_en0), .wr_index(req_index), .wr_entry(tag_wr_entry),
		.rd_entry(tag_entry0)
	);

	dcache_store_array #(.entry_t(tag_entry_t)) u_tag1 (
		.CLK(CLK), .RESET(RESET), .rd_index(req_index),
		.wr_en(tag_wr_en1), .wr_index(req_index), .wr_entry(tag_wr_entry),
		.rd_entry(tag_entry1)
	);

	dcache_hit_path u_hit_path (
		.CLK(CLK), .RESET(RESET), .read(read), .write(write), .addr(addr),
		.store_size(store_size), .write_data(write_data),
		.tag_entry0(tag_entry0), .tag_entry1(tag_entry1),
		.line0(line0), .line1(line1), .fill(fill), .fill_line(read_blk),
		.read_data(read_data), .stall(stall), .miss(miss),
		.victim_way(), .victim_entry(victim_entry),
		.victim_line(victim_line),
		.tag_wr_en0(tag_wr_en0), .tag_wr_en1(tag_wr_en1),
		.data_wr_en0(data_wr_en0), .data_wr_en1(data_wr_en1),
		.tag_wr_entry(tag_wr_entry), .data_wr_line(data_wr_line)
	);

	dcache_miss_seq u_miss_seq (
		.CLK(CLK), .RESET(RESET), .miss(miss), .addr(addr),
		.victim_entry(victim_entry), .victim_line(victim_line),
		.fill(fill), .blk_read(blk_read), .blk_write(blk_write),
		.mem_addr(mem_addr), .write_blk(write_blk)
	);

endmodule

// File: dcache_checker.sv
`include "dcache_defs.svh"

module dcache_checker (
	input  logic                         CLK,
	input  logic                         RESET,
	input  logic                         read,
	input  logic                         write,
	input  dcache_addr_pkg::addr_t       addr,
	input  dcache_line_pkg::store_size_e store_size,
	input  dcache_line_pkg::word_t       write_data,
	input  dcache_line_pkg::word_t       read_data,
	input  logic                         stall,
	input  logic                         blk_read,
	input  logic                         blk_write,
	input  dcache_addr_pkg::addr_t       mem_addr,
	input  dcache_line_pkg::line_t       write_blk,
	input  dcache_line_pkg::word_t       mem_key,
	input  logic [8*16-1:0]              test_name,
	input  logic                         file_check,
	input  dcache_line_pkg::word_t       file_expect,
	output int                           error_count
);

	import dcache_line_pkg::*;

	// reference 2-way cache, ref_last holds the last used way
	logic                     ref_valid [2][`DCACHE_SETS];
	logic                     ref_dirty [2][`DCACHE_SETS];
	logic [`DCACHE_TAG_W-1:0] ref_tag   [2][`DCACHE_SETS];
	line_t                    ref_line  [2][`DCACHE_SETS];
	logic                     ref_last  [`DCACHE_SETS];
	line_t                    shadow    [4096];
	logic                     shadow_ok [4096];
	int                       miss_cycle;

	initial begin
		error_count = 0;
		for (int i = 0; i < 4096; i++) begin
			shadow_ok[i] = 1'b0;
		end
	end

	// untouched lines follow the memory fill rule
	function automatic line_t memory_line(logic [31:0] base);
		line_t l;
		if (shadow_ok[base[16:5]]) begin
			return shadow[base[16:5]];
		end
		for (int w = 0; w < 8; w++) begin
			l[(7 - w) * 32 +: 32] = mem_key ^ ((base + 4 * w) * 32'h9e37_79b1);
		end
		return l;
	endfunction

	task automatic compare_value(input string what, input line_t expected, input line_t actual);
		if (expected !== actual) begin
			error_count++;
			$display("ERR %0s: %0s expected %0h actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic expect_quiet_port();
		compare_value("blk_read", 0, blk_read);
		compare_value("blk_write", 0, blk_write);
		compare_value("idle mem_addr", `DCACHE_IDLE_ADDR, mem_addr);
	endtask

	always @(posedge CLK or negedge RESET) begin
		logic [`DCACHE_TAG_W-1:0] tag;
		logic [8:0]               idx;
		logic [31:0]              line_addr;
		int                       lsb;
		int                       hit_way;
		int                       victim;
		logic                     wb;
		word_t                    mask;
		if (!RESET) begin
			for (int s = 0; s < `DCACHE_SETS; s++) begin
				ref_valid[0][s] = 1'b0;
				ref_valid[1][s] = 1'b0;
				ref_last[s] = 1'b0;
			end
			miss_cycle = 0;
		end else if (read || write) begin
			tag = addr[31:14];
			idx = addr[13:5];
			lsb = (7 - addr[4:2]) * 32;
			hit_way = -1;
			for (int w = 0; w < 2; w++) begin
				if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
					hit_way = w;
				end
			end
			if (hit_way >= 0) begin
				compare_value("stall on hit", 0, stall);
				expect_quiet_port();
				if (read) begin
					compare_value("load data", ref_line[hit_way][idx][lsb +: 32], read_data);
					if (file_check) begin
						compare_value("load data from file", file_expect, read_data);
					end
				end else begin
					case (store_size)
						SIZE_BYTE:   mask = 32'h0000_00ff;
						SIZE_HALF:   mask = 32'h0000_ffff;
						SIZE_TRIPLE: mask = 32'h00ff_ffff;
						default:     mask = 32'hffff_ffff;
					endcase
					ref_line[hit_way][idx][lsb +: 32] =
						(ref_line[hit_way][idx][lsb +: 32] & ~mask) | (write_data & mask);
					ref_dirty[hit_way][idx] = 1'b1;
				end
				ref_last[idx] = hit_way[0];
				miss_cycle = 0;
			end else begin
				// the least recently used way goes
				victim = ref_last[idx] ? 0 : 1;
				wb = (miss_cycle == 1) && ref_valid[victim][idx] && ref_dirty[victim][idx];
				compare_value("stall on miss", 1, stall);
				compare_value("blk_write", wb, blk_write);
				compare_value("blk_read", miss_cycle == 10, blk_read);
				if (wb) begin
					line_addr = {ref_tag[victim][idx], idx, 5'b0};
					compare_value("writeback mem_addr", line_addr, mem_addr);
					compare_value("write_blk", ref_line[victim][idx], write_blk);
					shadow[line_addr[16:5]] = ref_line[victim][idx];
					shadow_ok[line_addr[16:5]] = 1'b1;
				end else if (miss_cycle == 10) begin
					line_addr = {tag, idx, 5'b0};
					compare_value("refill mem_addr", line_addr, mem_addr);
					ref_line[victim][idx] = memory_line(line_addr);
					ref_tag[victim][idx] = tag;
					ref_valid[victim][idx] = 1'b1;
					ref_dirty[victim][idx] = 1'b0;
				end else begin
					compare_value("idle mem_addr", `DCACHE_IDLE_ADDR, mem_addr);
				end
				miss_cycle = (miss_cycle == 10) ? 0 : miss_cycle + 1;
			end
		end else begin
			compare_value("stall while idle", 0, stall);
			expect_quiet_port();
			miss_cycle = 0;
		end
	end

endmodule

// File: tb_dcache.sv
`include "dcache_defs.svh"

module tb_dcache;

	import dcache_addr_pkg::*;
	import dcache_line_pkg::*;

	logic            CLK;
	logic            RESET;
	logic            read;
	logic            write;
	addr_t           addr;
	store_size_e     store_size;
	word_t           write_data;
	line_t           read_blk;
	word_t           read_data;
	logic            stall;
	logic            blk_read;
	logic            blk_write;
	addr_t           mem_addr;
	line_t           write_blk;
	word_t           mem_key;
	logic [8*16-1:0] test_name;
	logic            file_check;
	word_t           file_expect;
	int              error_count;
	int              failures;

	// 4096 lines, room for tags 0 to 7
	line_t           mem [4096];

	dcache_top UUT (
		.CLK(CLK), .RESET(RESET), .read(read), .write(write), .addr(addr),
		.store_size(store_size), .write_data(write_data), .read_blk(read_blk),
		.read_data(read_data), .stall(stall), .blk_read(blk_read),
		.blk_write(blk_write), .mem_addr(mem_addr), .write_blk(write_blk)
	);

	dcache_checker u_checker (
		.CLK(CLK), .RESET(RESET), .read(read), .write(write), .addr(addr),
		.store_size(store_size), .write_data(write_data), .read_data(read_data),
		.stall(stall), .blk_read(blk_read), .blk_write(blk_write),
		.mem_addr(mem_addr), .write_blk(write_blk), .mem_key(mem_key),
		.test_name(test_name), .file_check(file_check), .file_expect(file_expect),
		.error_count(error_count)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// memory serves the line at mem_addr and takes writebacks at the edge
	assign read_blk = mem[mem_addr[16:5]];

	always @(posedge CLK) begin
		if (blk_write) begin
			mem[mem_addr[16:5]] <= write_blk;
		end
	end

	// word select 0 in the top bits, every word set by its own address
	function automatic line_t pattern_line(addr_t base);
		line_t l;
		for (int w = 0; w < `DCACHE_WORDS; w++) begin
			l[(`DCACHE_WORDS - 1 - w) * 32 +: 32] = mem_key ^ ((base + 4 * w) * 32'h9e37_79b1);
		end
		return l;
	endfunction

	task automatic run_access(input byte op, input addr_t a, input int size, input word_t data,
			input word_t exp_word, input logic [8*16-1:0] name, output logic timed_out);
		int waited;
		@(negedge CLK);
		test_name = name;
		read = (op != "S");
		write = (op == "S");
		addr = a;
		store_size = store_size_e'(size[1:0]);
		write_data = data;
		file_expect = exp_word;
		file_check = (op == "L");
		waited = 0;
		@(posedge CLK);
		while (stall && waited < 40) begin
			@(posedge CLK);
			waited++;
		end
		timed_out = stall;
		if (stall) begin
			$display("timeout: stall still high 40 cycles into %0s access at %h", test_name, a);
		end
	endtask

	initial begin
		int              fd;
		int              fields;
		string           text;
		byte             op;
		addr_t           a;
		int              size;
		word_t           data;
		word_t           exp_word;
		logic [8*16-1:0] name;
		logic            stuck;
		RESET = 1'b0;
		read = 1'b0;
		write = 1'b0;
		addr = '0;
		store_size = SIZE_WORD;
		write_data = '0;
		file_check = 1'b0;
		file_expect = '0;
		test_name = "reset";
		failures = 0;
		stuck = 1'b0;
		void'($urandom(16712));
		mem_key = $urandom;
		for (int i = 0; i < 4096; i++) begin
			mem[i] = pattern_line(addr_t'(i) << 5);
		end
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b1;
		// a few idle cycles, checker expects a quiet memory port
		test_name = "idle";
		repeat (3) @(posedge CLK);
		fd = $fopen("dcache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open dcache_stimulus.txt");
			failures++;
		end else begin
			while (!stuck && $fgets(text, fd) > 0) begin
				if (text[0] != "#") begin
					fields = $sscanf(text, "%c %h %d %h %h %s", op, a, size, data, exp_word,
						name);
					if (fields == 6) begin
						run_access(op, a, size, data, exp_word, name, stuck);
					end
				end
			end
			$fclose(fd);
		end
		@(negedge CLK);
		read = 1'b0;
		write = 1'b0;
		@(posedge CLK);
		if (stuck) begin
			failures++;
		end
		$display("errors: %0d mismatches, %0d other failures", error_count, failures);
		if (error_count == 0 && failures == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: dcache_stimulus.txt
# columns: op (R load, L load also checked against expect, S store), address,
# store size, store data, expected load value, test name
R 00004020 0 00000000 00000000 cold_miss
R 0000403c 0 00000000 00000000 load_hit
R 00004028 0 00000000 00000000 load_hit
S 00004030 0 11223344 00000000 store_word
L 00004030 0 00000000 11223344 store_word
S 00004030 1 556677aa 00000000 store_byte
L 00004030 0 00000000 112233aa store_byte
S 00004030 2 9988bbcc 00000000 store_half
L 00004030 0 00000000 1122bbcc store_half
S 00004030 3 77ddeeff 00000000 store_triple
L 00004030 0 00000000 11ddeeff store_triple
R 000080a0 0 00000000 00000000 lru_evict
R 0000c0a0 0 00000000 00000000 lru_evict
R 000080a0 0 00000000 00000000 lru_evict
R 000100a0 0 00000000 00000000 lru_evict
R 000080a0 0 00000000 00000000 lru_evict
R 0000c0a0 0 00000000 00000000 lru_evict
S 00004120 0 cafef00d 00000000 dirty_evict
S 0000413c 0 0badc0de 00000000 dirty_evict
R 00008120 0 00000000 00000000 dirty_evict
R 0000c120 0 00000000 00000000 dirty_evict
L 00004120 0 00000000 cafef00d dirty_evict
L 0000413c 0 00000000 0badc0de dirty_evict

// File: files.f
+incdir+.
dcache_addr_pkg.sv
dcache_line_pkg.sv
dcache_store_array.sv
dcache_hit_path.sv
dcache_miss_seq.sv
dcache_top.sv
dcache_checker.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - .

sources:
  - dcache_addr_pkg.sv
  - dcache_line_pkg.sv
  - dcache_store_array.sv
  - dcache_hit_path.sv
  - dcache_miss_seq.sv
  - dcache_top.sv
  - target: test
    files:
      - dcache_checker.sv
      - tb_dcache.sv
